/* src.f */
fft_stream_pkg.sv
fft_ctrl_pkg.sv
fft_settings.sv
cplx_mag_approx.sv
cplx_mag_sq.sv
mag_out_select.sv
fft_mag_top.sv
fft_mag_sva.sv
tb_fft_mag.sv

/* Makefile */
# Verilator build and run for the spectrum output stage

VERILATOR ?= verilator
TOP       ?= tb_fft_mag
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_fft_mag.sv */
/*
 * Testbench for the spectrum output stage: LCG stimulus,
 * reference model, scoreboard and test sequence
 */

`timescale 1ns/1ps

module tb_fft_mag;

  localparam int SR_BASE = 131;
  localparam int LIMIT   = 500;

  logic                         ce_clk = 1'b0;
  logic                         i_rst;
  fft_ctrl_pkg::setting_bus_t   i_set;
  logic [7:0]                   i_rb_addr;
  logic [63:0]                  o_rb_data;
  fft_stream_pkg::stream_beat_t i_in_beat;
  logic                         i_in_valid;
  logic                         o_in_ready;
  fft_stream_pkg::stream_beat_t o_out_beat;
  logic                         o_out_valid;
  logic                         i_out_ready;

  fft_stream_pkg::stream_beat_t exp_q[$];
  int                           cyc_q[$];
  logic [31:0]                  lcg_state = 32'd36;
  logic [1:0]                   cur_mode = 2'd0;
  bit                           check_latency = 1'b0;
  string                        test_name = "reset";
  int                           cycle_cnt = 0;
  int                           errors = 0;
  int                           checked = 0;
  int                           tests = 0;
  int                           err_base = 0;
  int                           chk_base = 0;

  fft_mag_top #(.SR_BASE(SR_BASE)) i_dut (.*);

  always #5 ce_clk = ~ce_clk;

  ////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic fft_stream_pkg::stream_beat_t make_beat(input bit extremes, input bit first);
    fft_stream_pkg::stream_beat_t beat;
    logic [15:0]                  corner [4];
    logic [15:0]                  r;
    corner    = '{16'h8000, 16'h7FFF, 16'h8001, 16'h0000};
    beat.data = {next_rand(), next_rand()};
    r         = next_rand();
    if (extremes && r[0]) beat.data[31:16] = corner[r[2:1]];
    if (extremes && r[3]) beat.data[15:0] = corner[r[5:4]];
    if (extremes && first) beat.data = 32'h8000_8000;
    beat.last = (r[9:7] == 3'd0);
    return beat;
  endfunction

  function automatic fft_stream_pkg::stream_beat_t model_beat(
    input logic [1:0] mode, input fft_stream_pkg::stream_beat_t in_beat);
    fft_stream_pkg::stream_beat_t exp_beat;
    int                           vi;
    int                           vq;
    int                           mx;
    int                           mn;
    int                           mag;
    longint                       scaled;
    vi = $signed(in_beat.data[31:16]);
    vq = $signed(in_beat.data[15:0]);
    if (vi < 0) vi = -vi;
    if (vq < 0) vq = -vq;
    mx  = (vi > vq) ? vi : vq;
    mn  = (vi > vq) ? vq : vi;
    mag = mx + mn / 4 + mn / 8;
    scaled = (longint'(vi) * vi + longint'(vq) * vq + 16384) / 32768;
    exp_beat.last = in_beat.last;
    case (mode)
      2'd1:    exp_beat.data = {16'((mag > 32767) ? 32767 : mag), 16'd0};
      2'd2:    exp_beat.data = {16'((scaled > 32767) ? 32767 : scaled), 16'd0};
      default: exp_beat.data = in_beat.data;
    endcase
    return exp_beat;
  endfunction

  // Scoreboard with expected words queued at input acceptance
  always @(posedge ce_clk) begin
    fft_stream_pkg::stream_beat_t exp_beat;
    int                           lat;
    if (!i_rst && o_out_valid && i_out_ready) begin
      if (exp_q.size() == 0) begin
        $display("error %s: output beat %h arrived with nothing pending", test_name, o_out_beat);
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        lat      = cycle_cnt - cyc_q.pop_front();
        checked++;
        if (o_out_beat !== exp_beat) begin
          $display("error %s: beat expected %h actual %h", test_name, exp_beat, o_out_beat);
          errors++;
        end
        if (check_latency && lat != 3) begin
          $display("error %s: latency expected 3 actual %0d", test_name, lat);
          errors++;
        end
      end
    end
    if (!i_rst && i_in_valid && o_in_ready) begin
      exp_q.push_back(model_beat(cur_mode, i_in_beat));
      cyc_q.push_back(cycle_cnt);
    end
    cycle_cnt++;
  end

  ////////////////////////////////////////////////////////////
  // Tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("timeout in %s: %s", test_name, why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base  = errors;
    chk_base  = checked;
  endtask

  task automatic end_test();
    tests++;
    $display("%s: %0d beats checked, %0d errors", test_name, checked - chk_base,
             errors - err_base);
  endtask

  task automatic write_reg(input int addr, input logic [31:0] data);
    @(posedge ce_clk);
    i_set <= '{stb: 1'b1, addr: 8'(addr), data: data};
    @(posedge ce_clk);
    i_set <= '0;
  endtask

  task automatic check_rb(input logic [7:0] addr, input logic [63:0] exp_data);
    @(posedge ce_clk);
    i_rb_addr <= addr;
    @(posedge ce_clk);
    if (o_rb_data !== exp_data) begin
      $display("error %s: readback %0d expected %h actual %h", test_name, addr, exp_data,
               o_rb_data);
      errors++;
    end
  endtask

  task automatic set_mode(input logic [1:0] mode);
    write_reg(SR_BASE + 2, 32'(mode));
    cur_mode = mode;
    check_rb(8'd1, 64'(mode));
  endtask

  task automatic run_stream(input int n_beats, input bit gaps, input bit extremes,
                            input bit hold_out);
    int sent;
    int idle;
    sent = 0;
    idle = 0;
    check_latency = !gaps && !hold_out;
    i_out_ready <= !hold_out;
    while (sent < n_beats) begin
      @(posedge ce_clk);
      if (i_in_valid && o_in_ready) begin
        sent++;
        idle = 0;
      end else begin
        idle++;
      end
      if (idle > LIMIT) abort_run("input beat never accepted");
      if (gaps) i_out_ready <= (next_rand() % 4) != 0;
      if (sent == n_beats) begin
        i_in_valid <= 1'b0;
      end else if (!i_in_valid || o_in_ready) begin
        // Gap cycles only where no beat is pending
        if (gaps && (next_rand() % 3) == 0) begin
          i_in_valid <= 1'b0;
        end else begin
          i_in_valid <= 1'b1;
          i_in_beat  <= make_beat(extremes, sent == 0);
        end
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge ce_clk);
      i_out_ready <= 1'b1;
      n++;
      if (n > LIMIT) abort_run("expected beats never came out");
    end
  endtask

  task automatic wait_out_idle();
    int n;
    n = 0;
    while (o_out_valid) begin
      @(posedge ce_clk);
      n++;
      if (n > LIMIT) abort_run("o_out_valid stayed high after soft reset");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    i_rst       = 1'b1;
    i_set       = '0;
    i_rb_addr   = 8'd0;
    i_in_beat   = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b0;
    repeat (16) @(posedge ce_clk);
    i_rst <= 1'b0;

    begin_test("reset_state");
    @(posedge ce_clk);
    if (o_out_valid !== 1'b0) begin
      $display("error %s: o_out_valid expected 0 actual %b", test_name, o_out_valid);
      errors++;
    end
    check_rb(8'd1, 64'd0);
    check_rb(8'd5, 64'h0BAD_C0DE_0BAD_C0DE);
    end_test();

    begin_test("complex_flow");
    set_mode(fft_ctrl_pkg::COMPLEX_OUT);
    run_stream(200, 1'b0, 1'b0, 1'b0);
    wait_drain();
    end_test();

    begin_test("mag_extremes");
    set_mode(fft_ctrl_pkg::MAG_OUT);
    run_stream(200, 1'b0, 1'b1, 1'b0);
    wait_drain();
    end_test();

    begin_test("mag_sq_extremes");
    set_mode(fft_ctrl_pkg::MAG_SQ_OUT);
    run_stream(200, 1'b0, 1'b1, 1'b0);
    wait_drain();
    end_test();

    for (int m = 0; m < 3; m++) begin
      begin_test($sformatf("gaps_mode%0d", m));
      set_mode(2'(m));
      run_stream(150, 1'b1, 1'b1, 1'b0);
      wait_drain();
      end_test();
    end

    // Three beats stalled in the pipeline and then dropped
    begin_test("soft_reset");
    set_mode(fft_ctrl_pkg::MAG_OUT);
    run_stream(3, 1'b0, 1'b0, 1'b1);
    @(posedge ce_clk);
    if (o_out_valid !== 1'b1 || o_in_ready !== 1'b0) begin
      $display("error %s: stall expected valid 1 ready 0 actual valid %b ready %b", test_name,
               o_out_valid, o_in_ready);
      errors++;
    end
    write_reg(SR_BASE, 32'd1);
    wait_out_idle();
    check_rb(8'd0, 64'd1);
    exp_q.delete();
    cyc_q.delete();
    i_out_ready <= 1'b1;
    repeat (8) @(posedge ce_clk);
    write_reg(SR_BASE, 32'd0);
    check_rb(8'd0, 64'd0);
    run_stream(60, 1'b1, 1'b1, 1'b0);
    wait_drain();
    end_test();

    $display("%0d tests, %0d beats checked, %0d errors", tests, checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* fft_mag_sva.sv */
/*
 * Bound assertions on the output handshake and the reset state
 */

`timescale 1ns/1ps

module fft_mag_sva (
  input logic                         ce_clk,
  input logic                         i_rst,
  input logic                         i_pipe_rst,
  input logic                         i_in_valid,
  input logic                         i_in_ready,
  input fft_stream_pkg::stream_beat_t i_out_beat,
  input logic                         i_out_valid,
  input logic                         i_out_ready
);

  // Beats accepted and not yet delivered
  int in_flight;

  always_ff @(posedge ce_clk) begin
    if (i_pipe_rst) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(i_in_valid && i_in_ready) - int'(i_out_valid && i_out_ready);
    end
  end

  a_idle_after_reset: assert property (@(posedge ce_clk) i_rst |=> !i_out_valid)
    else $error("o_out_valid high in the cycle after reset");

  a_hold_stable: assert property (@(posedge ce_clk) disable iff (i_pipe_rst)
    (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_beat)))
    else $error("output beat changed or dropped while stalled");

  a_no_phantom: assert property (@(posedge ce_clk) disable iff (i_pipe_rst)
    $rose(i_out_valid) |-> (in_flight > 0))
    else $error("o_out_valid rose with no accepted input beat");

endmodule

bind fft_mag_top fft_mag_sva i_sva (
  .ce_clk      (ce_clk),
  .i_rst       (i_rst),
  .i_pipe_rst  (pipe_rst),
  .i_in_valid  (i_in_valid),
  .i_in_ready  (o_in_ready),
  .i_out_beat  (o_out_beat),
  .i_out_valid (o_out_valid),
  .i_out_ready (i_out_ready)
);

/* fft_mag_top.sv */
/*
 * Spectrum output stage top level: settings, magnitude engines and combiner
 */

`timescale 1ns/1ps

module fft_mag_top #(
  parameter int unsigned SR_BASE = 131
) (
  input  logic                         ce_clk,
  input  logic                         i_rst,
  input  fft_ctrl_pkg::setting_bus_t   i_set,
  input  logic [7:0]                   i_rb_addr,
  output logic [63:0]                  o_rb_data,
  input  fft_stream_pkg::stream_beat_t i_in_beat,
  input  logic                         i_in_valid,
  output logic                         o_in_ready,
  output fft_stream_pkg::stream_beat_t o_out_beat,
  output logic                         o_out_valid,
  input  logic                         i_out_ready
);

  fft_ctrl_pkg::mag_mode_e   mode;
  logic                      pipe_rst;
  fft_stream_pkg::mag_beat_t mag_beat;
  logic                      mag_valid;
  logic [31:0]               mag_sq;

  fft_settings #(
    .SR_BASE(SR_BASE)
  ) i_settings (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_set      (i_set),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_mode     (mode),
    .o_pipe_rst (pipe_rst)
  );

  ////////////////////////////////////////////////////////////
  // Engines, both stepped by the combiner's advance
  ////////////////////////////////////////////////////////////

  cplx_mag_approx i_mag_approx (
    .ce_clk     (ce_clk),
    .i_pipe_rst (pipe_rst),
    .i_advance  (o_in_ready),
    .i_beat     (i_in_beat),
    .i_valid    (i_in_valid),
    .o_beat     (mag_beat),
    .o_valid    (mag_valid)
  );

  cplx_mag_sq i_mag_sq (
    .ce_clk     (ce_clk),
    .i_pipe_rst (pipe_rst),
    .i_advance  (o_in_ready),
    .i_beat     (i_in_beat),
    .o_mag_sq   (mag_sq)
  );

  mag_out_select i_out_select (
    .ce_clk      (ce_clk),
    .i_pipe_rst  (pipe_rst),
    .i_mode      (mode),
    .i_mag       (mag_beat),
    .i_mag_valid (mag_valid),
    .i_mag_sq    (mag_sq),
    .o_advance   (o_in_ready),
    .o_beat      (o_out_beat),
    .o_valid     (o_out_valid),
    .i_ready     (i_out_ready)
  );

endmodule

/* mag_out_select.sv */
/*
 * Output register with mode select, round and clip to 16 bits,
 * and the advance signal for the whole pipeline
 */

`timescale 1ns/1ps

module mag_out_select (
  input  logic                         ce_clk,
  input  logic                         i_pipe_rst,
  input  fft_ctrl_pkg::mag_mode_e      i_mode,
  input  fft_stream_pkg::mag_beat_t    i_mag,
  input  logic                         i_mag_valid,
  input  logic [31:0]                  i_mag_sq,
  output logic                         o_advance,
  output fft_stream_pkg::stream_beat_t o_beat,
  output logic                         o_valid,
  input  logic                         i_ready
);

  logic [15:0]                  mag_clip;
  logic [32:0]                  sq_round;
  logic [17:0]                  sq_scaled;
  logic [15:0]                  sq_clip;
  fft_stream_pkg::stream_beat_t next_beat;

  fft_stream_pkg::stream_beat_t beat_q;
  logic                         valid_q;

  ////////////////////////////////////////////////////////////
  // Result selection
  ////////////////////////////////////////////////////////////

  assign mag_clip = (i_mag.mag > 17'(fft_ctrl_pkg::OUT_MAX)) ?
                    fft_ctrl_pkg::OUT_MAX : i_mag.mag[15:0];

  // Round half up before dropping 15 fraction bits
  assign sq_round  = 33'(i_mag_sq) + 33'd16384;
  assign sq_scaled = sq_round[32:15];
  assign sq_clip   = (sq_scaled > 18'(fft_ctrl_pkg::OUT_MAX)) ?
                     fft_ctrl_pkg::OUT_MAX : sq_scaled[15:0];

  always_comb begin
    next_beat.last = i_mag.last;
    case (i_mode)
      fft_ctrl_pkg::MAG_OUT:    next_beat.data = {mag_clip, 16'd0};
      fft_ctrl_pkg::MAG_SQ_OUT: next_beat.data = {sq_clip, 16'd0};
      default:                  next_beat.data = i_mag.bin;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output register and flow control
  ////////////////////////////////////////////////////////////

  // Pipeline moves when the output slot is free or being drained
  assign o_advance = !valid_q || i_ready;

  always_ff @(posedge ce_clk) begin
    if (o_advance) begin
      beat_q <= next_beat;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_pipe_rst) begin
      valid_q <= 1'b0;
    end else if (o_advance) begin
      valid_q <= i_mag_valid;
    end
  end

  assign o_beat  = beat_q;
  assign o_valid = valid_q;

endmodule

/* cplx_mag_sq.sv */
/*
 * Two stage I squared plus Q squared engine
 */

`timescale 1ns/1ps

module cplx_mag_sq (
  input  logic                         ce_clk,
  input  logic                         i_pipe_rst,
  input  logic                         i_advance,
  input  fft_stream_pkg::stream_beat_t i_beat,
  output logic [31:0]                  o_mag_sq
);

  fft_stream_pkg::sc16_t in_bin;
  logic signed [31:0]    prod_i;
  logic signed [31:0]    prod_q;

  logic [31:0]           sq_i_q;
  logic [31:0]           sq_q_q;
  logic [31:0]           sum_q;

  assign in_bin = fft_stream_pkg::sc16_t'(i_beat.data);

  // Squares are never negative, largest is 2^30
  assign prod_i = in_bin.i * in_bin.i;
  assign prod_q = in_bin.q * in_bin.q;

  ////////////////////////////////////////////////////////////
  // Pipeline, moves in step with the approximator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_pipe_rst) begin
      sq_i_q <= '0;
      sq_q_q <= '0;
      sum_q  <= '0;
    end else if (i_advance) begin
      sq_i_q <= 32'(prod_i);
      sq_q_q <= 32'(prod_q);
      sum_q  <= sq_i_q + sq_q_q;
    end
  end

  assign o_mag_sq = sum_q;

endmodule

/* cplx_mag_approx.sv */
/*
 * Two stage max plus scaled min magnitude estimate,
 * original bin and last flag carried alongside
 */

`timescale 1ns/1ps

module cplx_mag_approx (
  input  logic                       ce_clk,
  input  logic                       i_pipe_rst,
  input  logic                       i_advance,
  input  fft_stream_pkg::stream_beat_t i_beat,
  input  logic                       i_valid,
  output fft_stream_pkg::mag_beat_t  o_beat,
  output logic                       o_valid
);

  fft_stream_pkg::sc16_t in_bin;
  logic [15:0]           abs_i;
  logic [15:0]           abs_q;

  // Stage one
  logic [15:0]           abs_i_q;
  logic [15:0]           abs_q_q;
  fft_stream_pkg::sc16_t bin_1_q;
  logic                  last_1_q;
  logic                  valid_1_q;

  // Stage two
  logic [15:0]           max_v;
  logic [15:0]           min_v;
  fft_stream_pkg::mag_beat_t beat_2_q;
  logic                  valid_2_q;

  assign in_bin = fft_stream_pkg::sc16_t'(i_beat.data);

  // -32768 wraps to 16'h8000, which read unsigned is 32768
  assign abs_i = in_bin.i[15] ? 16'(-in_bin.i) : 16'(in_bin.i);
  assign abs_q = in_bin.q[15] ? 16'(-in_bin.q) : 16'(in_bin.q);

  assign max_v = (abs_i_q >= abs_q_q) ? abs_i_q : abs_q_q;
  assign min_v = (abs_i_q >= abs_q_q) ? abs_q_q : abs_i_q;

  always_ff @(posedge ce_clk) begin
    if (i_advance) begin
      abs_i_q       <= abs_i;
      abs_q_q       <= abs_q;
      bin_1_q       <= in_bin;
      last_1_q      <= i_beat.last;
      beat_2_q.mag  <= 17'(max_v) + 17'(min_v >> 2) + 17'(min_v >> 3);
      beat_2_q.bin  <= bin_1_q;
      beat_2_q.last <= last_1_q;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_pipe_rst) begin
      valid_1_q <= 1'b0;
      valid_2_q <= 1'b0;
    end else if (i_advance) begin
      valid_1_q <= i_valid;
      valid_2_q <= valid_1_q;
    end
  end

  assign o_beat  = beat_2_q;
  assign o_valid = valid_2_q;

endmodule

/* fft_settings.sv */
/*
 * Settings register decode for output mode and soft reset,
 * combined pipeline reset and readback mux
 */

`timescale 1ns/1ps

module fft_settings #(
  parameter int unsigned SR_BASE = 131
) (
  input  logic                       ce_clk,
  input  logic                       i_rst,
  input  fft_ctrl_pkg::setting_bus_t i_set,
  input  logic [7:0]                 i_rb_addr,
  output logic [63:0]                o_rb_data,
  output fft_ctrl_pkg::mag_mode_e    o_mode,
  output logic                       o_pipe_rst
);

  localparam logic [7:0] RESET_ADDR = 8'(SR_BASE + fft_ctrl_pkg::SR_RESET_OFFS);
  localparam logic [7:0] MODE_ADDR  = 8'(SR_BASE + fft_ctrl_pkg::SR_MODE_OFFS);

  logic                    soft_rst_q;
  fft_ctrl_pkg::mag_mode_e mode_q;
  logic                    wr_reset;
  logic                    wr_mode;

  ////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////

  assign wr_reset = i_set.stb && (i_set.addr == RESET_ADDR);
  assign wr_mode  = i_set.stb && (i_set.addr == MODE_ADDR);

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      soft_rst_q <= 1'b0;
      mode_q     <= fft_ctrl_pkg::COMPLEX_OUT;
    end else begin
      if (wr_reset) begin
        soft_rst_q <= i_set.data[0];
      end
      if (wr_mode) begin
        mode_q <= fft_ctrl_pkg::mag_mode_e'(i_set.data[1:0]);
      end
    end
  end

  // Soft reset holds the datapath until cleared by software
  assign o_pipe_rst = i_rst | soft_rst_q;
  assign o_mode     = mode_q;

  ////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (i_rb_addr)
      fft_ctrl_pkg::RB_RESET_ADDR: o_rb_data = {63'd0, soft_rst_q};
      fft_ctrl_pkg::RB_MODE_ADDR:  o_rb_data = {62'd0, mode_q};
      default:                     o_rb_data = fft_ctrl_pkg::RB_BAD_ADDR;
    endcase
  end

endmodule

/* fft_ctrl_pkg.sv */
/*
 * Output mode encoding, settings bus type, register map and readback constants
 */

package fft_ctrl_pkg;

  // Codes above MAG_SQ_OUT fall back to the complex bypass
  typedef enum logic [1:0] {
    COMPLEX_OUT = 2'd0,
    MAG_OUT     = 2'd1,
    MAG_SQ_OUT  = 2'd2
  } mag_mode_e;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_bus_t;

  // Offsets from the block's settings base
  localparam int unsigned SR_RESET_OFFS = 0;
  localparam int unsigned SR_MODE_OFFS  = 2;

  localparam logic [7:0]  RB_RESET_ADDR = 8'd0;
  localparam logic [7:0]  RB_MODE_ADDR  = 8'd1;
  localparam logic [63:0] RB_BAD_ADDR   = 64'h0BAD_C0DE_0BAD_C0DE;

  // Largest positive sc16 value
  localparam logic [15:0] OUT_MAX = 16'd32767;

endpackage

/* fft_stream_pkg.sv */
/*
 * Complex sample and stream beat types for the magnitude datapath
 */

package fft_stream_pkg;

  // Complex FFT bin, I in the upper half
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } sc16_t;

  // One beat of the input or output stream
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } stream_beat_t;

  // Approximator result with the original bin carried along
  typedef struct packed {
    logic [16:0] mag;
    sc16_t       bin;
    logic        last;
  } mag_beat_t;

  localparam int unsigned SAMPLE_W = 16;
  localparam int unsigned MAG_W    = 17;

endpackage
